/* verilog/tpuPkg.sv */
package tpuPkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////
	localparam int numEntry    = 16;                // Reorder buffer depth
	localparam int numUnit     = 3;
	localparam int numMaster   = 4;                 // Units plus host port
	localparam int issueWidth  = 6;
	localparam int addrWidth   = 8;
	localparam int dataWidth   = 32;
	localparam int entryWidth  = $clog2(numEntry);
	localparam int masterWidth = $clog2(numMaster);

	////////////////////////////////////////
	// Types
	////////////////////////////////////////
	typedef logic [issueWidth-1:0] issueNo_t;       // Wrapping number unique while in flight
	typedef logic [entryWidth-1:0] entryIdx_t;
	typedef logic [addrWidth-1:0]  addr_t;
	typedef logic [dataWidth-1:0]  data_t;

	typedef enum logic [1:0] {
		opCopy,
		opAdd,
		opXor
	} opCode_t;

	// Execution unit sequence
	typedef enum logic [1:0] {
		sIdle,
		sRead,
		sWrite,
		sCommit
	} execState_t;

endpackage

/* verilog/busIf.sv */
`timescale 1ns/1ps

// Wishbone classic between one master and one slave
interface wbIf;
	logic            cyc;
	logic            stb;
	logic            we;
	tpuPkg::addr_t   adr;
	tpuPkg::data_t   datW;
	tpuPkg::data_t   datR;
	logic            ack;

	modport master(output cyc, stb, we, adr, datW, input datR, ack);
	modport slave(input cyc, stb, we, adr, datW, output datR, ack);
endinterface

// Issue unit to execution unit
interface dispatchIf;
	logic              valid;
	logic              ready;           // High only while the unit is idle
	tpuPkg::opCode_t   op;
	tpuPkg::addr_t     src;
	tpuPkg::addr_t     dst;
	tpuPkg::data_t     imm;
	tpuPkg::issueNo_t  issueNo;

	modport source(output valid, op, src, dst, imm, issueNo, input ready);
	modport sink(input valid, op, src, dst, imm, issueNo, output ready);
endinterface

/* verilog/ringBuffCtrl.sv */
`timescale 1ns/1ps

module ringBuffCtrl (
	input  logic              clock,
	input  logic              reset,
	input  logic              we,
	input  logic              re,
	output tpuPkg::entryIdx_t wAddr,
	output tpuPkg::entryIdx_t rAddr,
	output logic              full,
	output logic              empty
);

	logic [tpuPkg::entryWidth:0] count;     // One bit wider than an index
	logic doWrite;
	logic doRead;

	assign full    = (count == (tpuPkg::entryWidth + 1)'(tpuPkg::numEntry));
	assign empty   = (count == '0);
	assign doWrite = we & ~full;
	assign doRead  = re & ~empty;

	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr <= '0;
			rAddr <= '0;
			count <= '0;
		end else begin
			if (doWrite)
				wAddr <= wAddr + 1'b1;      // Wraps at the buffer depth
			if (doRead)
				rAddr <= rAddr + 1'b1;
			if (doWrite & ~doRead)
				count <= count + 1'b1;
			else if (doRead & ~doWrite)
				count <= count - 1'b1;
		end
	end

endmodule

/* verilog/reorderBuff.sv */
`timescale 1ns/1ps

module reorderBuff (
	input  logic             clock,
	input  logic             reset,
	input  logic             store,
	input  tpuPkg::issueNo_t issueNo,
	input  logic             commitReq [tpuPkg::numUnit],
	input  tpuPkg::issueNo_t commitNo [tpuPkg::numUnit],
	output logic             full,
	output logic             retireValid,
	output tpuPkg::issueNo_t retireNo
);

	////////////////////////////////////////
	// Commit table
	////////////////////////////////////////
	logic [tpuPkg::numEntry-1:0] entryValid;
	logic [tpuPkg::numEntry-1:0] entryDone;
	tpuPkg::issueNo_t            entryNo [tpuPkg::numEntry];

	logic [tpuPkg::numEntry-1:0] setDone;
	tpuPkg::entryIdx_t           wAddr;
	tpuPkg::entryIdx_t           rAddr;
	logic                        empty;
	logic                        write;
	logic                        retire;

	assign write  = store & ~full;
	assign retire = ~empty & entryDone[rAddr];     // Only the head retires

	// Match every live entry against all units
	always_comb begin
		for (int i = 0; i < tpuPkg::numEntry; i++) begin
			setDone[i] = 1'b0;
			for (int u = 0; u < tpuPkg::numUnit; u++) begin
				setDone[i] = setDone[i] |
					(entryValid[i] & commitReq[u] & (entryNo[i] == commitNo[u]));
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			entryValid  <= '0;
			entryDone   <= '0;
			retireValid <= 1'b0;
		end else begin
			retireValid <= retire;
			entryDone   <= entryDone | setDone;
			if (write) begin
				entryValid[wAddr] <= 1'b1;
				entryDone[wAddr]  <= 1'b0;
			end
			if (retire) begin
				entryValid[rAddr] <= 1'b0;
				entryDone[rAddr]  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (write)
			entryNo[wAddr] <= issueNo;
		if (retire)
			retireNo <= entryNo[rAddr];                // Reported with retireValid
	end

	ringBuffCtrl ringBuffCtrl_inst (
		.clock (clock),
		.reset (reset),
		.we    (write),
		.re    (retire),
		.wAddr (wAddr),
		.rAddr (rAddr),
		.full  (full),
		.empty (empty)
	);

endmodule

/* verilog/issueUnit.sv */
`timescale 1ns/1ps

module issueUnit (
	input  logic             clock,
	input  logic             reset,
	input  logic             instValid,
	output logic             instReady,
	input  tpuPkg::opCode_t  instOp,
	input  tpuPkg::addr_t    instSrc,
	input  tpuPkg::addr_t    instDst,
	input  tpuPkg::data_t    instImm,
	input  logic             robFull,
	output logic             store,
	output tpuPkg::issueNo_t issueNo,
	dispatchIf.source        dispatch [tpuPkg::numUnit]
);

	logic [tpuPkg::numUnit-1:0] unitReady;
	logic [tpuPkg::numUnit-1:0] unitSel;       // One-hot lowest idle unit
	logic                       accept;
	tpuPkg::issueNo_t           issueCnt;

	assign unitSel   = unitReady & (~unitReady + 1'b1);
	assign instReady = ~robFull & (|unitReady);
	assign accept    = instValid & instReady;
	assign store     = accept;                 // Same cycle as dispatch
	assign issueNo   = issueCnt;

	////////////////////////////////////////
	// Per unit dispatch
	////////////////////////////////////////
	for (genvar u = 0; u < tpuPkg::numUnit; u++) begin : genDispatch
		assign unitReady[u]         = dispatch[u].ready;
		assign dispatch[u].valid    = accept & unitSel[u];
		assign dispatch[u].op       = instOp;
		assign dispatch[u].src      = instSrc;
		assign dispatch[u].dst      = instDst;
		assign dispatch[u].imm      = instImm;
		assign dispatch[u].issueNo  = issueCnt;
	end

	always_ff @(posedge clock) begin
		if (reset)
			issueCnt <= '0;
		else if (accept)
			issueCnt <= issueCnt + 1'b1;       // Wraps modulo 64
	end

endmodule

/* verilog/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
	input  logic             clock,
	input  logic             reset,
	dispatchIf.sink          dispatch,
	wbIf.master              bus,
	output logic             commitReq,
	output tpuPkg::issueNo_t commitNo
);

	tpuPkg::execState_t state;
	tpuPkg::opCode_t    opReg;
	tpuPkg::addr_t      srcReg;
	tpuPkg::addr_t      dstReg;
	tpuPkg::data_t      immReg;
	tpuPkg::issueNo_t   noReg;
	tpuPkg::data_t      result;
	logic               take;

	assign take           = dispatch.valid & dispatch.ready;
	assign dispatch.ready = (state == tpuPkg::sIdle);

	// Bus stays claimed from read through write
	assign bus.cyc  = (state == tpuPkg::sRead) | (state == tpuPkg::sWrite);
	assign bus.stb  = bus.cyc;
	assign bus.we   = (state == tpuPkg::sWrite);
	assign bus.adr  = (state == tpuPkg::sWrite) ? dstReg : srcReg;
	assign bus.datW = result;

	assign commitReq = (state == tpuPkg::sCommit);  // Cycle after write ack
	assign commitNo  = noReg;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= tpuPkg::sIdle;
		end else begin
			unique case (state)
				tpuPkg::sIdle:   if (take) state <= tpuPkg::sRead;
				tpuPkg::sRead:   if (bus.ack) state <= tpuPkg::sWrite;
				tpuPkg::sWrite:  if (bus.ack) state <= tpuPkg::sCommit;
				tpuPkg::sCommit: state <= tpuPkg::sIdle;
				default:         state <= tpuPkg::sIdle;
			endcase
		end
	end

	////////////////////////////////////////
	// Operand latch and compute
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (take) begin
			opReg  <= dispatch.op;
			srcReg <= dispatch.src;
			dstReg <= dispatch.dst;
			immReg <= dispatch.imm;
			noReg  <= dispatch.issueNo;
		end
		if (state == tpuPkg::sRead && bus.ack) begin
			unique case (opReg)
				tpuPkg::opAdd: result <= bus.datR + immReg;   // Modulo 2^32
				tpuPkg::opXor: result <= bus.datR ^ immReg;
				default:       result <= bus.datR;            // Copy
			endcase
		end
	end

endmodule

/* verilog/wbArbiter.sv */
`timescale 1ns/1ps

module wbArbiter (
	input  logic clock,
	input  logic reset,
	wbIf.slave   masters [tpuPkg::numMaster],
	wbIf.master  slave
);

	logic                          masterCyc [tpuPkg::numMaster];
	logic                          masterStb [tpuPkg::numMaster];
	logic                          masterWe  [tpuPkg::numMaster];
	tpuPkg::addr_t                 masterAdr [tpuPkg::numMaster];
	tpuPkg::data_t                 masterDatW [tpuPkg::numMaster];

	logic                          locked;
	logic [tpuPkg::masterWidth-1:0] grantIdx;
	logic [tpuPkg::masterWidth-1:0] rrPtr;      // Highest priority master
	logic [tpuPkg::masterWidth-1:0] nextIdx;
	logic                          reqFound;

	for (genvar m = 0; m < tpuPkg::numMaster; m++) begin : genMaster
		assign masterCyc[m]   = masters[m].cyc;
		assign masterStb[m]   = masters[m].stb;
		assign masterWe[m]    = masters[m].we;
		assign masterAdr[m]   = masters[m].adr;
		assign masterDatW[m]  = masters[m].datW;
		assign masters[m].datR = slave.datR;
		assign masters[m].ack  = slave.ack & locked & (grantIdx == m);
	end

	// Granted master drives the slave side
	assign slave.cyc  = locked & masterCyc[grantIdx];
	assign slave.stb  = locked & masterStb[grantIdx];
	assign slave.we   = masterWe[grantIdx];
	assign slave.adr  = masterAdr[grantIdx];
	assign slave.datW = masterDatW[grantIdx];

	////////////////////////////////////////
	// Round-robin search from rrPtr
	////////////////////////////////////////
	always_comb begin
		int cand;
		nextIdx  = rrPtr;
		reqFound = 1'b0;
		for (int k = 0; k < tpuPkg::numMaster; k++) begin
			cand = (int'(rrPtr) + k) % tpuPkg::numMaster;
			if (!reqFound && masterCyc[cand]) begin
				reqFound = 1'b1;
				nextIdx  = tpuPkg::masterWidth'(cand);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			locked   <= 1'b0;
			grantIdx <= '0;
			rrPtr    <= '0;
		end else begin
			if (!locked) begin
				if (reqFound) begin
					locked   <= 1'b1;
					grantIdx <= nextIdx;
				end
			end else if (!masterCyc[grantIdx]) begin
				locked <= 1'b0;            // Cycle over so the bus is free
			end
			if (slave.ack)
				rrPtr <= tpuPkg::masterWidth'((int'(grantIdx) + 1) % tpuPkg::numMaster);
		end
	end

endmodule

/* verilog/scratchMem.sv */
`timescale 1ns/1ps

module scratchMem (
	input  logic clock,
	input  logic reset,
	wbIf.slave   bus
);

	tpuPkg::data_t mem [0:(1 << tpuPkg::addrWidth)-1];
	logic          access;

	// Skips the cycle that already acks
	assign access = bus.cyc & bus.stb & ~bus.ack;

	always_ff @(posedge clock) begin
		if (reset)
			bus.ack <= 1'b0;
		else
			bus.ack <= access;          // One cycle after stb
	end

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (access) begin
			if (bus.we)
				mem[bus.adr] <= bus.datW;
			bus.datR <= mem[bus.adr];   // Valid together with ack
		end
	end

endmodule

/* verilog/tpuCommit.sv */
`timescale 1ns/1ps

module tpuCommit (
	input  logic             clock,
	input  logic             reset,
	input  logic             instValid,
	output logic             instReady,
	input  tpuPkg::opCode_t  instOp,
	input  tpuPkg::addr_t    instSrc,
	input  tpuPkg::addr_t    instDst,
	input  tpuPkg::data_t    instImm,
	output logic             retireValid,
	output tpuPkg::issueNo_t retireNo,
	input  logic             hostCyc,
	input  logic             hostStb,
	input  logic             hostWe,
	input  tpuPkg::addr_t    hostAdr,
	input  tpuPkg::data_t    hostDatW,
	output tpuPkg::data_t    hostDatR,
	output logic             hostAck
);

	wbIf       masterBus [tpuPkg::numMaster] ();
	wbIf       memBus ();
	dispatchIf dispatchBus [tpuPkg::numUnit] ();

	logic             robFull;
	logic             store;
	tpuPkg::issueNo_t issueNo;
	logic             commitReq [tpuPkg::numUnit];
	tpuPkg::issueNo_t commitNo [tpuPkg::numUnit];

	////////////////////////////////////////
	// Host port is the last bus master
	////////////////////////////////////////
	assign masterBus[tpuPkg::numMaster-1].cyc  = hostCyc;
	assign masterBus[tpuPkg::numMaster-1].stb  = hostStb;
	assign masterBus[tpuPkg::numMaster-1].we   = hostWe;
	assign masterBus[tpuPkg::numMaster-1].adr  = hostAdr;
	assign masterBus[tpuPkg::numMaster-1].datW = hostDatW;
	assign hostDatR = masterBus[tpuPkg::numMaster-1].datR;
	assign hostAck  = masterBus[tpuPkg::numMaster-1].ack;

	issueUnit issueUnit_inst (
		.clock     (clock),
		.reset     (reset),
		.instValid (instValid),
		.instReady (instReady),
		.instOp    (instOp),
		.instSrc   (instSrc),
		.instDst   (instDst),
		.instImm   (instImm),
		.robFull   (robFull),
		.store     (store),
		.issueNo   (issueNo),
		.dispatch  (dispatchBus)
	);

	for (genvar u = 0; u < tpuPkg::numUnit; u++) begin : genUnit
		execUnit execUnit_inst (
			.clock     (clock),
			.reset     (reset),
			.dispatch  (dispatchBus[u]),
			.bus       (masterBus[u]),
			.commitReq (commitReq[u]),
			.commitNo  (commitNo[u])
		);
	end

	reorderBuff reorderBuff_inst (
		.clock       (clock),
		.reset       (reset),
		.store       (store),
		.issueNo     (issueNo),
		.commitReq   (commitReq),
		.commitNo    (commitNo),
		.full        (robFull),
		.retireValid (retireValid),
		.retireNo    (retireNo)
	);

	wbArbiter wbArbiter_inst (
		.clock   (clock),
		.reset   (reset),
		.masters (masterBus),
		.slave   (memBus)
	);

	scratchMem scratchMem_inst (
		.clock (clock),
		.reset (reset),
		.bus   (memBus)
	);

endmodule

/* dv/tbTpuCommit.sv */
`timescale 1ns/1ps

module tbTpuCommit;

	localparam int numResult  = 50;                     // Random instructions of the results phase
	localparam int numHold    = 16;                     // Instructions offered while bus held
	localparam int totalInst  = numResult + numHold;    // Crosses the 64 issue number wrap
	localparam int numSrc     = 64;
	localparam int dstBase    = 64;
	localparam int holdCycles = 40;
	localparam int timeoutCycles = 200 * totalInst + 1000;

	logic             clock;
	logic             reset;
	logic             instValid;
	logic             instReady;
	tpuPkg::opCode_t  instOp;
	tpuPkg::addr_t    instSrc;
	tpuPkg::addr_t    instDst;
	tpuPkg::data_t    instImm;
	logic             retireValid;
	tpuPkg::issueNo_t retireNo;
	logic             hostCyc;
	logic             hostStb;
	logic             hostWe;
	tpuPkg::addr_t    hostAdr;
	tpuPkg::data_t    hostDatW;
	tpuPkg::data_t    hostDatR;
	logic             hostAck;

	logic [31:0]      rngState = 32'hff911d9b;
	tpuPkg::data_t    srcWords [numSrc];
	tpuPkg::data_t    expWords [totalInst];
	tpuPkg::issueNo_t issueQ [$];                       // Issue numbers in acceptance order
	int               acceptCount = 0;
	int               retireCount = 0;
	logic             busHeld = 1'b0;                   // Host owns the bus and units stall

	tpuCommit tpuCommit_inst (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	////////////////////////////////////////
	// Reference model and random source
	////////////////////////////////////////
	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic tpuPkg::data_t refResult(tpuPkg::opCode_t op, tpuPkg::data_t src,
			tpuPkg::data_t imm);
		case (op)
			tpuPkg::opAdd: return src + imm;            // Wraps at 32 bits
			tpuPkg::opXor: return src ^ imm;
			default:       return src;
		endcase
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input tpuPkg::data_t got,
			input tpuPkg::data_t exp);
		if (got !== exp)
			stopOnError($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkIssueNo(input string name, input tpuPkg::issueNo_t got,
			input tpuPkg::issueNo_t exp);
		if (got !== exp)
			stopOnError($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stopOnError($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	////////////////////////////////////////
	// Host port and instruction drivers
	////////////////////////////////////////
	// Called and returns 1 ns after a rising edge
	task automatic hostAccess(input logic write, input tpuPkg::addr_t adr,
			input tpuPkg::data_t datW, output tpuPkg::data_t datR);
		hostCyc  = 1'b1;
		hostStb  = 1'b1;
		hostWe   = write;
		hostAdr  = adr;
		hostDatW = datW;
		@(negedge clock);
		while (!hostAck) @(negedge clock);
		datR = hostDatR;
		@(posedge clock);
		#1;
		hostCyc = 1'b0;
		hostStb = 1'b0;
		hostWe  = 1'b0;
	endtask

	task automatic hostWrite(input tpuPkg::addr_t adr, input tpuPkg::data_t datW);
		tpuPkg::data_t unused;
		hostAccess(1'b1, adr, datW, unused);
	endtask

	task automatic hostRead(input tpuPkg::addr_t adr, output tpuPkg::data_t datR);
		hostAccess(1'b0, adr, '0, datR);
	endtask

	// Read held open so no unit can reach memory
	task automatic holdBus(input int cycles);
		hostCyc = 1'b1;
		hostStb = 1'b1;
		hostWe  = 1'b0;
		hostAdr = '0;
		@(negedge clock);
		while (!hostAck) @(negedge clock);
		busHeld = 1'b1;
		repeat (cycles) @(posedge clock);
		#1;
		busHeld = 1'b0;
		hostCyc = 1'b0;
		hostStb = 1'b0;
	endtask

	task automatic issueRandom(input int idx);
		tpuPkg::opCode_t op;
		tpuPkg::addr_t   src;
		tpuPkg::data_t   imm;
		op  = tpuPkg::opCode_t'(2'(nextRandom() % 3));
		src = tpuPkg::addr_t'(nextRandom() % numSrc);
		imm = nextRandom();
		expWords[idx] = refResult(op, srcWords[src], imm);
		instValid = 1'b1;
		instOp    = op;
		instSrc   = src;
		instDst   = tpuPkg::addr_t'(dstBase + idx);
		instImm   = imm;
		@(negedge clock);
		while (!instReady) @(negedge clock);
		issueQ.push_back(tpuPkg::issueNo_t'(acceptCount));   // Modulo 64
		@(posedge clock);
		acceptCount++;                                       // Accepted on this edge
		#1;
		instValid = 1'b0;
	endtask

	task automatic waitRetired(input int count);
		while (retireCount < count) @(negedge clock);
	endtask

	////////////////////////////////////////
	// Retirement checker
	////////////////////////////////////////
	initial begin
		int outstanding;
		forever begin
			@(negedge clock);
			if (!reset) begin
				if (retireValid) begin
					if (issueQ.size() == 0)
						stopOnError("Retirement seen with no instruction outstanding");
					checkIssueNo("retireNo", retireNo, issueQ.pop_front());
					retireCount++;
				end
				outstanding = acceptCount - retireCount;
				if (outstanding < tpuPkg::numUnit)
					checkBit("instReady", instReady, 1'b1);     // Some unit must be idle
				if (busHeld && outstanding >= tpuPkg::numUnit)
					checkBit("instReady", instReady, 1'b0);     // All units stalled
			end
		end
	end

	initial begin
		repeat (timeoutCycles) @(posedge clock);
		stopOnError($sformatf("Timeout after %0d cycles, the run did not finish", timeoutCycles));
	end

	initial begin
		tpuPkg::data_t readWord;
		reset     = 1'b1;
		instValid = 1'b0;
		instOp    = tpuPkg::opCopy;
		instSrc   = '0;
		instDst   = '0;
		instImm   = '0;
		hostCyc   = 1'b0;
		hostStb   = 1'b0;
		hostWe    = 1'b0;
		hostAdr   = '0;
		hostDatW  = '0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		checkBit("retireValid", retireValid, 1'b0);
		checkBit("instReady", instReady, 1'b1);
		@(posedge clock);
		#1;

		// Source words in and back out
		for (int i = 0; i < numSrc; i++) begin
			srcWords[i] = nextRandom();
			hostWrite(tpuPkg::addr_t'(i), srcWords[i]);
		end
		for (int i = 0; i < numSrc; i++) begin
			hostRead(tpuPkg::addr_t'(i), readWord);
			checkData("hostDatR", readWord, srcWords[i]);
		end

		for (int i = 0; i < numResult; i++)
			issueRandom(i);
		waitRetired(numResult);
		@(posedge clock);
		#1;

		// Back-pressure with the host sitting on the bus
		fork
			holdBus(holdCycles);
			for (int j = 0; j < numHold; j++)
				issueRandom(numResult + j);
		join
		waitRetired(totalInst);
		@(posedge clock);
		#1;

		for (int i = 0; i < totalInst; i++) begin
			hostRead(tpuPkg::addr_t'(dstBase + i), readWord);
			checkData("hostDatR", readWord, expWords[i]);
		end

		$display("Test passed");
		$finish;
	end

endmodule

/* tpuCommit.f */
verilog/tpuPkg.sv
verilog/busIf.sv
verilog/ringBuffCtrl.sv
verilog/reorderBuff.sv
verilog/issueUnit.sv
verilog/execUnit.sv
verilog/wbArbiter.sv
verilog/scratchMem.sv
verilog/tpuCommit.sv
dv/tbTpuCommit.sv

/* run.sh */
#!/usr/bin/env bash
# Build the tpuCommit testbench with Verilator, run it, then search the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbTpuCommit \
	-f tpuCommit.f -Mdir obj_dir -o simTpuCommit \
	|| { echo "Build failed"; exit 1; }

./obj_dir/simTpuCommit | tee sim.log

grep -qx "Test passed" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
